/* src/asym_fifo_pkg.sv */
// shared widths and depth of the byte-in, word-out FIFO
// opcode enum of the stimulus file
package asym_fifo_pkg;

   // write side is one byte, read side one 32-bit word
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;

   // byte lanes per word, one RAM bank each
   localparam int RATIO = R_DATA_W / W_DATA_W;

   // 64 bytes of storage
   localparam int W_ADDR_W    = 6;
   localparam int R_ADDR_W    = W_ADDR_W - $clog2(RATIO);
   localparam int BANK_ADDR_W = R_ADDR_W;
   localparam int DEPTH       = 1 << W_ADDR_W;

   // occupancy in bytes, 0 up to DEPTH inclusive
   localparam int LEVEL_W = W_ADDR_W + 1;

   // stimulus opcodes
   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_IDLE,
      OP_RESET
   } tb_op_e;

endpackage

/* src/ext_mem_if.sv */
// banked memory write and read ports
// master side for the converter, slave side for the RAM
`timescale 1ns/1ps

interface ext_mem_if #(
   parameter int N_BANKS = asym_fifo_pkg::RATIO,
   parameter int DATA_W  = asym_fifo_pkg::R_DATA_W,
   parameter int ADDR_W  = asym_fifo_pkg::BANK_ADDR_W
) (
   input logic clk_i
);

   // write port, one enable per bank
   logic [N_BANKS-1:0] w_en;
   logic [ADDR_W-1:0]  w_addr;
   logic [DATA_W-1:0]  w_data;

   // read port, data one cycle after r_en
   logic [N_BANKS-1:0] r_en;
   logic [ADDR_W-1:0]  r_addr;
   logic [DATA_W-1:0]  r_data;

   modport mem_mst (
      input  clk_i,
      output w_en, w_addr, w_data,
      output r_en, r_addr,
      input  r_data
   );

   modport mem_slv (
      input  clk_i,
      input  w_en, w_addr, w_data,
      input  r_en, r_addr,
      output r_data
   );

endinterface

/* src/asym_converter.sv */
// asymmetric width converter between a request port pair and banked memory
// registered read valid, held read data
`timescale 1ns/1ps

module asym_converter #(
   parameter int  W_DATA_W   = asym_fifo_pkg::W_DATA_W,
   parameter int  R_DATA_W   = asym_fifo_pkg::R_DATA_W,
   parameter bit  BIG_ENDIAN = 1'b0,
   localparam int MAXDATA_W  = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MINDATA_W  = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int R          = MAXDATA_W / MINDATA_W,
   localparam int LOG_R      = $clog2(R),
   localparam int W_AW       = asym_fifo_pkg::BANK_ADDR_W + ((W_DATA_W < R_DATA_W) ? LOG_R : 0),
   localparam int R_AW       = asym_fifo_pkg::BANK_ADDR_W + ((W_DATA_W > R_DATA_W) ? LOG_R : 0)
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                w_en_i,
   input  logic [W_AW-1:0]     w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   input  logic                r_en_i,
   input  logic [R_AW-1:0]     r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_valid_o,
   ext_mem_if.mem_mst          mem
);

   logic                 r_valid_q;
   logic [MAXDATA_W-1:0] r_data_q;
   logic [MAXDATA_W-1:0] r_data_int;

   // memory answers one cycle after the request
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_valid_q <= 1'b0;
      end else begin
         r_valid_q <= r_en_i;
      end
   end

   // keep the last word for the cycles between reads
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_data_q <= '0;
      end else if (r_valid_q) begin
         r_data_q <= mem.r_data;
      end
   end

   // fresh data goes straight through
   assign r_data_int = r_valid_q ? mem.r_data : r_data_q;
   assign r_valid_o  = r_valid_q;

   generate
      if (W_DATA_W > R_DATA_W) begin : g_write_wider
         logic [LOG_R-1:0]     r_lane;
         logic [LOG_R-1:0]     r_lane_q;
         logic [MAXDATA_W-1:0] r_data;

         // whole word written across all banks
         assign mem.w_en   = {R{w_en_i}};
         assign mem.w_addr = w_addr_i;
         assign mem.w_data = w_data_i;

         // narrow read hits a single bank
         if (BIG_ENDIAN) begin : g_big_endian
            assign r_lane = LOG_R'(R - 1) - r_addr_i[LOG_R-1:0];
         end else begin : g_little_endian
            assign r_lane = r_addr_i[LOG_R-1:0];
         end

         assign mem.r_en   = {{(R - 1){1'b0}}, r_en_i} << r_lane;
         assign mem.r_addr = r_addr_i[R_AW-1:LOG_R];

         // lane select must line up with the returning data
         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               r_lane_q <= '0;
            end else if (r_en_i) begin
               r_lane_q <= r_lane;
            end
         end

         assign r_data   = r_data_int >> (r_lane_q * R_DATA_W);
         assign r_data_o = r_data[R_DATA_W-1:0];

      end else if (W_DATA_W < R_DATA_W) begin : g_read_wider
         logic [LOG_R-1:0] w_lane;

         // low address bits pick the bank of each narrow write
         assign w_lane     = w_addr_i[LOG_R-1:0];
         assign mem.w_en   = {{(R - 1){1'b0}}, w_en_i} << w_lane;
         assign mem.w_data = {{(R_DATA_W - W_DATA_W){1'b0}}, w_data_i} << (w_lane * W_DATA_W);
         assign mem.w_addr = w_addr_i[W_AW-1:LOG_R];

         // wide read takes every bank at once
         assign mem.r_en   = {R{r_en_i}};
         assign mem.r_addr = r_addr_i;

         if (BIG_ENDIAN) begin : g_big_endian
            // first byte written ends up in the top lane
            for (genvar lane = 0; lane < R; lane++) begin : g_lane
               assign r_data_o[lane*W_DATA_W +: W_DATA_W] =
                  r_data_int[(R - 1 - lane)*W_DATA_W +: W_DATA_W];
            end
         end else begin : g_little_endian
            assign r_data_o = r_data_int;
         end

      end else begin : g_same_width
         assign mem.w_en   = w_en_i;
         assign mem.w_addr = w_addr_i;
         assign mem.w_data = w_data_i;
         assign mem.r_en   = r_en_i;
         assign mem.r_addr = r_addr_i;
         assign r_data_o   = r_data_int;
      end
   endgenerate

endmodule

/* src/fifo_wr_ctrl.sv */
// write side of the FIFO
// byte pointer with wrap bit, full flag, write request to the converter
`timescale 1ns/1ps

module fifo_wr_ctrl (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               wr_en_i,
   input  logic [asym_fifo_pkg::R_ADDR_W:0]   rd_ptr_i,
   input  logic [asym_fifo_pkg::LEVEL_W-1:0]  level_i,
   output logic [asym_fifo_pkg::W_ADDR_W:0]   wr_ptr_o,
   output logic                               full_o,
   output logic                               w_en_o,
   output logic [asym_fifo_pkg::W_ADDR_W-1:0] w_addr_o
);

   import asym_fifo_pkg::*;

   logic [W_ADDR_W:0] wr_ptr_q;
   logic [W_ADDR_W:0] rd_byte_ptr;
   logic              ptr_lap;
   logic              wr_accept;

   // read pointer scaled to bytes
   assign rd_byte_ptr = {rd_ptr_i, {(W_ADDR_W - R_ADDR_W){1'b0}}};

   // pointers exactly one lap apart
   assign ptr_lap = (wr_ptr_q ^ rd_byte_ptr) == {1'b1, {W_ADDR_W{1'b0}}};

   assign full_o    = ptr_lap && (level_i == LEVEL_W'(DEPTH));
   assign wr_accept = wr_en_i && !full_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
      end else if (wr_accept) begin
         wr_ptr_q <= wr_ptr_q + 1'b1;
      end
   end

   assign wr_ptr_o = wr_ptr_q;

   // converter sees the byte address without the wrap bit
   assign w_en_o   = wr_accept;
   assign w_addr_o = wr_ptr_q[W_ADDR_W-1:0];

endmodule

/* src/fifo_rd_ctrl.sv */
// read side of the FIFO
// word pointer with wrap bit, byte occupancy, empty flag, read request
`timescale 1ns/1ps

module fifo_rd_ctrl (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               rd_en_i,
   input  logic [asym_fifo_pkg::W_ADDR_W:0]   wr_ptr_i,
   output logic [asym_fifo_pkg::R_ADDR_W:0]   rd_ptr_o,
   output logic [asym_fifo_pkg::LEVEL_W-1:0]  level_o,
   output logic                               empty_o,
   output logic                               r_en_o,
   output logic [asym_fifo_pkg::R_ADDR_W-1:0] r_addr_o
);

   import asym_fifo_pkg::*;

   logic [R_ADDR_W:0]  rd_ptr_q;
   logic [LEVEL_W-1:0] rd_byte_ptr;
   logic [LEVEL_W-1:0] level;
   logic               rd_accept;

   // word pointer times four, in bytes
   assign rd_byte_ptr = {rd_ptr_q, {(W_ADDR_W - R_ADDR_W){1'b0}}};

   // wrap bits make the difference correct modulo two laps
   assign level = wr_ptr_i - rd_byte_ptr;

   // a partial word cannot be read
   assign empty_o   = level < LEVEL_W'(RATIO);
   assign rd_accept = rd_en_i && !empty_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr_q <= '0;
      end else if (rd_accept) begin
         rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   assign rd_ptr_o = rd_ptr_q;
   assign level_o  = level;

   // word address to the converter
   assign r_en_o   = rd_accept;
   assign r_addr_o = rd_ptr_q[R_ADDR_W-1:0];

endmodule

/* src/banked_ram.sv */
// four byte-wide synchronous RAM banks
// per-bank write enable and registered read
`timescale 1ns/1ps

module banked_ram (
   input logic        clk_i,
   input logic        rst_n_i,
   ext_mem_if.mem_slv mem
);

   import asym_fifo_pkg::*;

   localparam int BANK_DEPTH = 1 << BANK_ADDR_W;

   generate
      for (genvar b = 0; b < RATIO; b++) begin : g_bank
         logic [W_DATA_W-1:0] bank_mem [BANK_DEPTH];
         logic [W_DATA_W-1:0] rd_q;

         // each bank stores its own byte lane
         always_ff @(posedge clk_i) begin
            if (mem.w_en[b]) begin
               bank_mem[mem.w_addr] <= mem.w_data[b*W_DATA_W +: W_DATA_W];
            end
         end

         // output register only moves on a read
         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               rd_q <= '0;
            end else if (mem.r_en[b]) begin
               rd_q <= bank_mem[mem.r_addr];
            end
         end

         assign mem.r_data[b*W_DATA_W +: W_DATA_W] = rd_q;
      end
   endgenerate

endmodule

/* src/asym_fifo_top.sv */
// byte-in, word-out FIFO top level
// write and read controllers, width converter, banked RAM
`timescale 1ns/1ps

module asym_fifo_top #(
   parameter bit BIG_ENDIAN = 1'b0
) (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              wr_en_i,
   input  logic [asym_fifo_pkg::W_DATA_W-1:0] wr_data_i,
   input  logic                              rd_en_i,
   output logic                              full_o,
   output logic                              empty_o,
   output logic [asym_fifo_pkg::LEVEL_W-1:0]  level_o,
   output logic [asym_fifo_pkg::R_DATA_W-1:0] rd_data_o,
   output logic                              rd_valid_o
);

   import asym_fifo_pkg::*;

   logic [W_ADDR_W:0]   wr_ptr;
   logic [R_ADDR_W:0]   rd_ptr;
   logic                w_en;
   logic [W_ADDR_W-1:0] w_addr;
   logic                r_en;
   logic [R_ADDR_W-1:0] r_addr;

   ext_mem_if mem_bus (.clk_i(clk_i));

   fifo_wr_ctrl u_wr_ctrl (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wr_en_i (wr_en_i),
      .rd_ptr_i(rd_ptr),
      .level_i (level_o),
      .wr_ptr_o(wr_ptr),
      .full_o  (full_o),
      .w_en_o  (w_en),
      .w_addr_o(w_addr)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .rd_en_i (rd_en_i),
      .wr_ptr_i(wr_ptr),
      .rd_ptr_o(rd_ptr),
      .level_o (level_o),
      .empty_o (empty_o),
      .r_en_o  (r_en),
      .r_addr_o(r_addr)
   );

   asym_converter #(
      .BIG_ENDIAN(BIG_ENDIAN)
   ) u_converter (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en),
      .w_addr_i (w_addr),
      .w_data_i (wr_data_i),
      .r_en_i   (r_en),
      .r_addr_i (r_addr),
      .r_data_o (rd_data_o),
      .r_valid_o(rd_valid_o),
      .mem      (mem_bus.mem_mst)
   );

   banked_ram u_ram (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .mem    (mem_bus.mem_slv)
   );

endmodule

/* tb/asym_fifo_checker.sv */
// reference byte queue and port comparisons for the byte-in, word-out FIFO
// one result line per finished test
`timescale 1ns/1ps

module asym_fifo_checker (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic                              wr_en_i,
   input  logic [asym_fifo_pkg::W_DATA_W-1:0] wr_data_i,
   input  logic                              rd_en_i,
   input  logic                              full_i,
   input  logic                              empty_i,
   input  logic [asym_fifo_pkg::LEVEL_W-1:0]  level_i,
   input  logic [asym_fifo_pkg::R_DATA_W-1:0] rd_data_i,
   input  logic                              rd_valid_i,
   input  logic                              exp_valid_i,
   input  logic [15:0]                       exp_level_i,
   input  logic                              test_end_i,
   input  logic [15:0]                       test_id_i,
   output int                                error_count_o,
   output int                                test_count_o,
   output int                                failed_tests_o
);

   import asym_fifo_pkg::*;

   logic [W_DATA_W-1:0] byte_q [$];
   logic [R_DATA_W-1:0] pending_word = '0;
   logic [R_DATA_W-1:0] held_word = '0;
   logic                valid_exp = 1'b0;
   logic                reset_held = 1'b0;
   int                  errors = 0;
   int                  tests = 0;
   int                  failed = 0;
   int                  test_errors = 0;

   assign error_count_o  = errors;
   assign test_count_o   = tests;
   assign failed_tests_o = failed;

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t: %s expected %0h, got %0h",
                  $time, name, expected, actual);
         errors++;
         test_errors++;
      end
   endtask

   always @(posedge clk_i) begin : model
      int stored;
      stored = byte_q.size();
      if (!rst_n_i) begin
         // reset values from the second clock of a reset on
         if (reset_held) begin
            compare_value("empty_o", 32'(1), 32'(empty_i));
            compare_value("full_o", 32'(0), 32'(full_i));
            compare_value("level_o", 32'(0), 32'(level_i));
            compare_value("rd_valid_o", 32'(0), 32'(rd_valid_i));
            compare_value("rd_data_o", 32'(0), 32'(rd_data_i));
         end
         byte_q.delete();
         valid_exp  = 1'b0;
         held_word  = '0;
         reset_held = 1'b1;
      end else begin
         reset_held = 1'b0;
         compare_value("level_o", 32'(stored), 32'(level_i));
         compare_value("empty_o", 32'(stored < RATIO), 32'(empty_i));
         compare_value("full_o", 32'(stored == DEPTH), 32'(full_i));
         compare_value("rd_valid_o", 32'(valid_exp), 32'(rd_valid_i));
         // word shows on the valid cycle and stays until the next one
         if (valid_exp) begin
            held_word = pending_word;
         end
         compare_value("rd_data_o", 32'(held_word), 32'(rd_data_i));
         valid_exp = 1'b0;
         // first byte written goes to bits 7:0
         if (rd_en_i && stored >= RATIO) begin
            for (int i = 0; i < RATIO; i++) begin
               pending_word[i*W_DATA_W +: W_DATA_W] = byte_q.pop_front();
            end
            valid_exp = 1'b1;
         end
         if (wr_en_i && stored < DEPTH) begin
            byte_q.push_back(wr_data_i);
         end
      end
      if (exp_valid_i) begin
         compare_value("level_o (case file)", 32'(exp_level_i), 32'(level_i));
      end
      if (test_end_i) begin
         tests++;
         if (test_errors == 0) begin
            $display("test %0d passed", test_id_i);
         end else begin
            $display("test %0d failed with %0d errors", test_id_i, test_errors);
            failed++;
         end
         test_errors = 0;
      end
   end

endmodule

/* tb/asym_fifo_tb.sv */
// testbench top for the byte-in, word-out FIFO
// clock, reset, case file reader, watchdog, DUT and checker
`timescale 1ns/1ps

module asym_fifo_tb;

   import asym_fifo_pkg::*;

   localparam int CLK_PERIOD      = 40;
   localparam int RESET_CYCLES    = 10;
   localparam int MAX_CASES       = 64;
   localparam int CYCLES_PER_CASE = 200;

   logic                clk;
   logic                rst_n;
   logic                wr_en;
   logic [W_DATA_W-1:0] wr_data;
   logic                rd_en;
   logic                full;
   logic                empty;
   logic [LEVEL_W-1:0]  level;
   logic [R_DATA_W-1:0] rd_data;
   logic                rd_valid;
   logic                exp_valid;
   logic [15:0]         exp_level;
   logic                test_end;
   logic [15:0]         test_id;
   int                  error_count;
   int                  test_count;
   int                  failed_tests;

   // each case line holds op, value, count, level and test
   logic [15:0] case_mem [5*MAX_CASES];
   int          n_cases = 0;
   logic        cases_loaded = 1'b0;

   asym_fifo_top dut (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .wr_en_i   (wr_en),
      .wr_data_i (wr_data),
      .rd_en_i   (rd_en),
      .full_o    (full),
      .empty_o   (empty),
      .level_o   (level),
      .rd_data_o (rd_data),
      .rd_valid_o(rd_valid)
   );

   asym_fifo_checker chk (
      .clk_i(clk), .rst_n_i(rst_n), .wr_en_i(wr_en), .wr_data_i(wr_data), .rd_en_i(rd_en),
      .full_i(full), .empty_i(empty), .level_i(level), .rd_data_i(rd_data),
      .rd_valid_i(rd_valid), .exp_valid_i(exp_valid), .exp_level_i(exp_level),
      .test_end_i(test_end), .test_id_i(test_id), .error_count_o(error_count),
      .test_count_o(test_count), .failed_tests_o(failed_tests)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // one case file line, then a cycle with the expected level
   task automatic run_case(input int idx);
      tb_op_e      op;
      logic [15:0] value;
      int          count;
      logic        last;
      op    = tb_op_e'(case_mem[5*idx][1:0]);
      value = case_mem[5*idx+1];
      count = int'(case_mem[5*idx+2]);
      last  = (idx == n_cases - 1) || (case_mem[5*idx+4] != case_mem[5*idx+9]);
      for (int c = 0; c < count; c++) begin
         @(negedge clk);
         exp_valid = 1'b0;
         test_end  = 1'b0;
         case (op)
            OP_WRITE: begin
               wr_en   = 1'b1;
               rd_en   = value[9];
               wr_data = value[8] ? 8'($urandom()) : value[7:0] + 8'(c);
            end
            OP_READ:  rd_en = 1'b1;
            OP_RESET: rst_n = 1'b0;
            default: begin
               wr_en = 1'b0;
               rd_en = 1'b0;
            end
         endcase
      end
      @(negedge clk);
      wr_en     = 1'b0;
      rd_en     = 1'b0;
      rst_n     = 1'b1;
      exp_valid = 1'b1;
      exp_level = case_mem[5*idx+3];
      test_id   = case_mem[5*idx+4];
      test_end  = last;
   endtask

   // run limit grows with the number of case lines
   initial begin
      wait (cases_loaded);
      #(CLK_PERIOD * (n_cases * CYCLES_PER_CASE + RESET_CYCLES));
      $display("timeout: case file did not complete within %0d cycles",
               n_cases * CYCLES_PER_CASE + RESET_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      rst_n     = 1'b0;
      wr_en     = 1'b0;
      wr_data   = '0;
      rd_en     = 1'b0;
      exp_valid = 1'b0;
      exp_level = '0;
      test_end  = 1'b0;
      test_id   = '0;
      void'($urandom(9));
      for (int i = 0; i < 5 * MAX_CASES; i++) begin
         case_mem[i] = '1;
      end
      $readmemh("tb/asym_fifo_cases.txt", case_mem);
      while (n_cases < MAX_CASES && case_mem[5*n_cases] != '1) begin
         n_cases++;
      end
      cases_loaded = 1'b1;
      if (n_cases == 0) begin
         $display("no test cases read from tb/asym_fifo_cases.txt");
      end
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < n_cases; i++) begin
         run_case(i);
      end
      @(negedge clk);
      exp_valid = 1'b0;
      test_end  = 1'b0;
      repeat (2) @(negedge clk);
      $display("tests run: %0d, tests failed: %0d, check errors: %0d",
               test_count, failed_tests, error_count);
      if (n_cases > 0 && error_count == 0 && failed_tests == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
src/asym_fifo_pkg.sv
src/ext_mem_if.sv
src/asym_converter.sv
src/fifo_wr_ctrl.sv
src/fifo_rd_ctrl.sv
src/banked_ram.sv
src/asym_fifo_top.sv
tb/asym_fifo_checker.sv
tb/asym_fifo_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= asym_fifo_tb
RTL_TOP   ?= asym_fifo_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ps
RTL_SRCS  ?= $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/asym_fifo_cases.txt */
// op value count level test, all hex; op 0 write, 1 read, 2 idle, 3 reset
// write value is the first byte, +1 per cycle; 100 random byte, 200 read in the same cycle
2 000 02 00 1
0 011 01 01 2
0 022 01 02 2
0 033 01 03 2
0 044 01 04 2
1 000 01 00 2
2 000 02 00 2
0 000 40 40 3
0 0ff 01 40 3
1 000 10 00 3
0 0c1 03 03 4
1 000 02 03 4
0 0c4 01 04 4
1 000 01 00 4
2 000 02 00 4
0 300 28 04 5
0 100 1e 22 5
0 300 14 02 5
0 100 02 04 5
1 000 01 00 5
0 055 05 05 6
3 000 03 00 6
2 000 02 00 6
